/* compile.f */
cache_pkg.sv
mem_pkg.sv
cache_array.sv
cache_ctrl.sv
mem_arbiter.sv
main_mem.sv
cache_subsys.sv
cache_properties.sv
cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsys

sources:
  - files:
      - cache_pkg.sv
      - mem_pkg.sv
      - cache_array.sv
      - cache_ctrl.sv
      - mem_arbiter.sv
      - main_mem.sv
      - cache_subsys.sv
  - target: test
    files:
      - cache_properties.sv
      - cache_tb.sv

/* cache_tb.sv */
/*
 * Directed testbench for the two-port cache subsystem.
 * A byte scoreboard tracks every completed write and predicts read data.
 */
`timescale 1ns/1ns

module cache_tb;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int HIT_CYCLES     = 2;

  logic             clk;
  logic             rst;
  logic             req   [2];
  logic             we    [2];
  cache_pkg::addr_t addr  [2];
  cache_pkg::size_e size  [2];
  cache_pkg::word_t wdata [2];
  logic             done  [2];
  cache_pkg::word_t rdata [2];
  // cycles from request to done, per port
  int               lat   [2];
  // expected memory contents by byte address
  logic [7:0]       sb    [cache_pkg::addr_t];
  integer           seed;
  int               assert_errors;

  cache_subsys cache_subsys_inst (
    .clk      (clk),
    .rst      (rst),
    .p0_req   (req[0]),
    .p0_we    (we[0]),
    .p0_addr  (addr[0]),
    .p0_size  (size[0]),
    .p0_wdata (wdata[0]),
    .p0_done  (done[0]),
    .p0_rdata (rdata[0]),
    .p1_req   (req[1]),
    .p1_we    (we[1]),
    .p1_addr  (addr[1]),
    .p1_size  (size[1]),
    .p1_wdata (wdata[1]),
    .p1_done  (done[1]),
    .p1_rdata (rdata[1])
  );

  bind cache_ctrl cache_properties props_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .done     (done),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_addr (mem_addr),
    .state    (state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopping after the first failure");
  endtask

  task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at time %0t: read data mismatch, got %h, expected %h",
                               $time, got, exp));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("ERROR at time %0t: hit latency %0d cycles, expected %0d",
                               $time, got, exp));
    end
  endtask

  function automatic cache_pkg::word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // zero-extended read value from the byte model
  // bytes never written stay X so the compare fails
  function automatic cache_pkg::word_t expected_read(input cache_pkg::addr_t a,
                                                     input cache_pkg::size_e sz);
    cache_pkg::word_t w;
    w = '0;
    for (int i = 0; i < (1 << sz); i++) begin
      w[i*8 +: 8] = sb.exists(a + i) ? sb[a + i] : 8'hxx;
    end
    return w;
  endfunction

  // one request on one port, held until done
  task automatic run_access(input int port, input logic wr, input cache_pkg::addr_t a,
                            input cache_pkg::size_e sz, input cache_pkg::word_t d,
                            output cache_pkg::word_t rd);
    int  cycles;
    bit  seen;
    @(posedge clk);
    #2;
    req[port]   = 1'b1;
    we[port]    = wr;
    addr[port]  = a;
    size[port]  = sz;
    wdata[port] = d;
    cycles      = 0;
    seen        = 1'b0;
    while (!seen) begin
      @(posedge clk);
      #1;
      cycles++;
      if (done[port]) begin
        seen = 1'b1;
      end else if (cycles >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("port %0d got no done within %0d cycles for address %h",
                                 port, TIMEOUT_CYCLES, a));
      end
    end
    rd        = rdata[port];
    lat[port] = cycles;
    @(posedge clk);
    #2;
    req[port] = 1'b0;
  endtask

  task automatic do_write(input int port, input cache_pkg::addr_t a,
                          input cache_pkg::size_e sz, input cache_pkg::word_t d);
    cache_pkg::word_t unused;
    run_access(port, 1'b1, a, sz, d, unused);
    for (int i = 0; i < (1 << sz); i++) begin
      sb[a + i] = d[i*8 +: 8];
    end
  endtask

  task automatic do_read(input int port, input cache_pkg::addr_t a,
                         input cache_pkg::size_e sz, output cache_pkg::word_t result);
    run_access(port, 1'b0, a, sz, '0, result);
  endtask

  task automatic read_check(input int port, input cache_pkg::addr_t a,
                            input cache_pkg::size_e sz);
    cache_pkg::word_t got;
    do_read(port, a, sz, got);
    check_word(got, expected_read(a, sz));
  endtask

  task automatic full_word_round_trip();
    do_write(0, 'h0100, cache_pkg::SIZE_64, rand_word());
    read_check(0, 'h0100, cache_pkg::SIZE_64);
  endtask

  task automatic subword_merge();
    do_write(0, 'h0200, cache_pkg::SIZE_64, rand_word());
    do_write(0, 'h0208, cache_pkg::SIZE_64, rand_word());
    // upper wdata bits must be ignored for the narrow writes
    do_write(0, 'h0203, cache_pkg::SIZE_8, rand_word());
    do_write(0, 'h020a, cache_pkg::SIZE_16, rand_word());
    do_write(0, 'h020c, cache_pkg::SIZE_32, rand_word());
    read_check(0, 'h0203, cache_pkg::SIZE_8);
    read_check(0, 'h0201, cache_pkg::SIZE_8);
    read_check(0, 'h020a, cache_pkg::SIZE_16);
    read_check(0, 'h0202, cache_pkg::SIZE_16);
    read_check(0, 'h020c, cache_pkg::SIZE_32);
    read_check(0, 'h0204, cache_pkg::SIZE_32);
    read_check(0, 'h0200, cache_pkg::SIZE_64);
    read_check(0, 'h0208, cache_pkg::SIZE_64);
  endtask

  task automatic write_through_visibility();
    do_write(0, 'h0300, cache_pkg::SIZE_64, rand_word());
    read_check(1, 'h0300, cache_pkg::SIZE_64);
  endtask

  // each port misses on the line the other one wrote
  task automatic concurrent_misses();
    do_write(0, 'h0400, cache_pkg::SIZE_64, rand_word());
    do_write(1, 'h0500, cache_pkg::SIZE_64, rand_word());
    fork
      read_check(0, 'h0500, cache_pkg::SIZE_64);
      read_check(1, 'h0400, cache_pkg::SIZE_64);
    join
  endtask

  // same index, addresses 0x1000 apart
  task automatic conflict_eviction();
    do_write(0, 'h0600, cache_pkg::SIZE_64, rand_word());
    do_write(0, 'h1600, cache_pkg::SIZE_64, rand_word());
    for (int i = 0; i < 3; i++) begin
      read_check(0, 'h0600, cache_pkg::SIZE_64);
      read_check(0, 'h1600, cache_pkg::SIZE_64);
    end
  endtask

  task automatic hit_latency();
    do_write(0, 'h0700, cache_pkg::SIZE_64, rand_word());
    read_check(0, 'h0700, cache_pkg::SIZE_64);
    check_latency(lat[0], HIT_CYCLES);
    read_check(1, 'h0300, cache_pkg::SIZE_64);
    check_latency(lat[1], HIT_CYCLES);
  endtask

  initial begin
    seed = 9;
    rst  = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req[p]   = 1'b0;
      we[p]    = 1'b0;
      addr[p]  = '0;
      size[p]  = cache_pkg::SIZE_8;
      wdata[p] = '0;
      lat[p]   = 0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    full_word_round_trip();
    subword_merge();
    write_through_visibility();
    concurrent_misses();
    conflict_eviction();
    hit_latency();

    assert_errors = cache_subsys_inst.cache0_inst.props_inst.error_count +
                    cache_subsys_inst.cache1_inst.props_inst.error_count;
    if (assert_errors == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_failure($sformatf("%0d handshake assertion failures were reported",
                               assert_errors));
    end
  end

endmodule

/* cache_properties.sv */
/*
 * Handshake assertions for one cache controller, bound into cache_ctrl.
 * error_count lets the testbench see failures at the end of the run.
 */
`timescale 1ns/1ns

module cache_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 req,
  input logic                 done,
  input logic                 mem_req,
  input logic                 mem_ack,
  input mem_pkg::line_addr_t  mem_addr,
  input mem_pkg::ctrl_state_e state
);

  int error_count = 0;

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      error_count++;
    end

  // request and line address held until the ack
  mem_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
    else begin
      $error("mem_req dropped or mem_addr changed before mem_ack");
      error_count++;
    end

  // done only ends a request that left IDLE and is still held
  done_not_idle: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> req && $past(state) != mem_pkg::IDLE)
    else begin
      $error("done rose without an accepted request");
      error_count++;
    end

endmodule

/* cache_subsys.sv */
/*
 * Top level: two requester ports, each with its own cache, sharing one
 * backing memory through a round-robin arbiter.
 */
`timescale 1ns/1ns

module cache_subsys #(
  parameter int NUM_LINES   = 64,
  parameter int MEM_LINES   = 1024,
  parameter int MEM_LATENCY = 4
) (
  input  logic             clk,
  input  logic             rst,
  // port 0
  input  logic             p0_req,
  input  logic             p0_we,
  input  cache_pkg::addr_t p0_addr,
  input  cache_pkg::size_e p0_size,
  input  cache_pkg::word_t p0_wdata,
  output logic             p0_done,
  output cache_pkg::word_t p0_rdata,
  // port 1
  input  logic             p1_req,
  input  logic             p1_we,
  input  cache_pkg::addr_t p1_addr,
  input  cache_pkg::size_e p1_size,
  input  cache_pkg::word_t p1_wdata,
  output logic             p1_done,
  output cache_pkg::word_t p1_rdata
);

  // cache 0 to arbiter
  logic                c0_req;
  logic                c0_we;
  mem_pkg::line_addr_t c0_addr;
  mem_pkg::line_t      c0_wdata;
  logic                c0_ack;
  mem_pkg::line_t      c0_rdata;

  // cache 1 to arbiter
  logic                c1_req;
  logic                c1_we;
  mem_pkg::line_addr_t c1_addr;
  mem_pkg::line_t      c1_wdata;
  logic                c1_ack;
  mem_pkg::line_t      c1_rdata;

  // arbiter to memory
  logic                s_req;
  logic                s_we;
  mem_pkg::line_addr_t s_addr;
  mem_pkg::line_t      s_wdata;
  logic                s_ack;
  mem_pkg::line_t      s_rdata;

  cache_ctrl #(.NUM_LINES(NUM_LINES)) cache0_inst (
    .clk (clk), .rst (rst),
    .req (p0_req), .we (p0_we), .addr (p0_addr), .size (p0_size),
    .wdata (p0_wdata), .done (p0_done), .rdata (p0_rdata),
    .mem_req (c0_req), .mem_we (c0_we), .mem_addr (c0_addr),
    .mem_wdata (c0_wdata), .mem_ack (c0_ack), .mem_rdata (c0_rdata)
  );

  cache_ctrl #(.NUM_LINES(NUM_LINES)) cache1_inst (
    .clk (clk), .rst (rst),
    .req (p1_req), .we (p1_we), .addr (p1_addr), .size (p1_size),
    .wdata (p1_wdata), .done (p1_done), .rdata (p1_rdata),
    .mem_req (c1_req), .mem_we (c1_we), .mem_addr (c1_addr),
    .mem_wdata (c1_wdata), .mem_ack (c1_ack), .mem_rdata (c1_rdata)
  );

  mem_arbiter arbiter_inst (
    .clk (clk), .rst (rst),
    .m0_req (c0_req), .m0_we (c0_we), .m0_addr (c0_addr), .m0_wdata (c0_wdata),
    .m0_ack (c0_ack), .m0_rdata (c0_rdata),
    .m1_req (c1_req), .m1_we (c1_we), .m1_addr (c1_addr), .m1_wdata (c1_wdata),
    .m1_ack (c1_ack), .m1_rdata (c1_rdata),
    .s_req (s_req), .s_we (s_we), .s_addr (s_addr), .s_wdata (s_wdata),
    .s_ack (s_ack), .s_rdata (s_rdata)
  );

  main_mem #(
    .MEM_LINES   (MEM_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) mem_inst (
    .clk (clk), .rst (rst),
    .mem_req (s_req), .mem_we (s_we), .mem_addr (s_addr), .mem_wdata (s_wdata),
    .mem_ack (s_ack), .mem_rdata (s_rdata)
  );

endmodule

/* main_mem.sv */
/*
 * Line-wide backing memory with a fixed ack latency.
 * Reads return the line with the ack; writes land at the ack.
 */
`timescale 1ns/1ns

module main_mem #(
  parameter int MEM_LINES   = 1024,
  parameter int MEM_LATENCY = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                mem_req,
  input  logic                mem_we,
  input  mem_pkg::line_addr_t mem_addr,
  input  mem_pkg::line_t      mem_wdata,
  output logic                mem_ack,
  output mem_pkg::line_t      mem_rdata
);

  localparam int IDX_BITS = $clog2(MEM_LINES);
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  mem_pkg::line_t      store [MEM_LINES];
  logic [IDX_BITS-1:0] idx;
  logic [CNT_BITS-1:0] cnt_q;
  logic                ack_q;

  // only the low line-address bits select a row
  assign idx = mem_addr[IDX_BITS-1:0];

  // count request cycles, ack lands MEM_LATENCY cycles after the first
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else if (ack_q) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else if (mem_req) begin
      if (cnt_q == CNT_BITS'(MEM_LATENCY - 1)) begin
        cnt_q <= '0;
        ack_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req && !ack_q) begin
      mem_rdata <= store[idx];
    end
    if (ack_q && mem_we) begin
      store[idx] <= mem_wdata;
    end
  end

  assign mem_ack = ack_q;

endmodule

/* mem_arbiter.sv */
/*
 * Round-robin arbiter giving one of two caches access to the backing
 * memory. The grant is held from the request until the memory ack.
 */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                clk,
  input  logic                rst,
  // port 0
  input  logic                m0_req,
  input  logic                m0_we,
  input  mem_pkg::line_addr_t m0_addr,
  input  mem_pkg::line_t      m0_wdata,
  output logic                m0_ack,
  output mem_pkg::line_t      m0_rdata,
  // port 1
  input  logic                m1_req,
  input  logic                m1_we,
  input  mem_pkg::line_addr_t m1_addr,
  input  mem_pkg::line_t      m1_wdata,
  output logic                m1_ack,
  output mem_pkg::line_t      m1_rdata,
  // shared memory side
  output logic                s_req,
  output logic                s_we,
  output mem_pkg::line_addr_t s_addr,
  output mem_pkg::line_t      s_wdata,
  input  logic                s_ack,
  input  mem_pkg::line_t      s_rdata
);

  // one-hot grant, zero when idle
  logic [1:0] grant_q;
  // high when port 1 was granted last
  logic       last_q;
  logic       pick1;

  // on a tie the port not served last wins
  assign pick1 = m1_req && (!m0_req || !last_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= 2'b00;
      last_q  <= 1'b1;
    end else if (grant_q == 2'b00) begin
      if (m0_req || m1_req) begin
        grant_q <= pick1 ? 2'b10 : 2'b01;
        last_q  <= pick1;
      end
    end else if (s_ack) begin
      grant_q <= 2'b00;
    end
  end

  assign s_req   = (grant_q[0] && m0_req) || (grant_q[1] && m1_req);
  assign s_we    = grant_q[1] ? m1_we    : m0_we;
  assign s_addr  = grant_q[1] ? m1_addr  : m0_addr;
  assign s_wdata = grant_q[1] ? m1_wdata : m0_wdata;

  // ack goes only to the granted port
  assign m0_ack   = s_ack && grant_q[0];
  assign m1_ack   = s_ack && grant_q[1];
  assign m0_rdata = s_rdata;
  assign m1_rdata = s_rdata;

endmodule

/* cache_ctrl.sv */
/*
 * Per-port cache controller: hit lookup, miss fill, byte merge and
 * write-through. Talks to one requester and to the memory arbiter.
 */
`timescale 1ns/1ns

module cache_ctrl #(
  parameter int NUM_LINES = 64
) (
  input  logic                clk,
  input  logic                rst,
  // requester side
  input  logic                req,
  input  logic                we,
  input  cache_pkg::addr_t    addr,
  input  cache_pkg::size_e    size,
  input  cache_pkg::word_t    wdata,
  output logic                done,
  output cache_pkg::word_t    rdata,
  // memory side
  output logic                mem_req,
  output logic                mem_we,
  output mem_pkg::line_addr_t mem_addr,
  output mem_pkg::line_t      mem_wdata,
  input  logic                mem_ack,
  input  mem_pkg::line_t      mem_rdata
);

  localparam int LANE_BITS = $clog2(cache_pkg::WORD_BYTES);

  mem_pkg::ctrl_state_e state;
  mem_pkg::ctrl_state_e state_next;

  logic           hit;
  logic           fill_en;
  logic           merge_en;
  mem_pkg::line_t cur_line;
  mem_pkg::line_t fill_buf;

  // pick the addressed bytes out of a line and zero-extend them
  function automatic cache_pkg::word_t extract(input mem_pkg::line_t line,
                                               input cache_pkg::addr_t a,
                                               input cache_pkg::size_e sz);
    cache_pkg::word_t w;
    w = line[a[cache_pkg::OFFSET_BITS-1:LANE_BITS] * cache_pkg::WORD_BITS +:
             cache_pkg::WORD_BITS];
    w = w >> (a[LANE_BITS-1:0] * 8);
    unique case (sz)
      cache_pkg::SIZE_8:  w = {56'd0, w[7:0]};
      cache_pkg::SIZE_16: w = {48'd0, w[15:0]};
      cache_pkg::SIZE_32: w = {32'd0, w[31:0]};
      default:            w = w;
    endcase
    return w;
  endfunction

  cache_array #(
    .NUM_LINES (NUM_LINES)
  ) array_inst (
    .clk         (clk),
    .rst         (rst),
    .lookup_addr (addr),
    .hit         (hit),
    .rd_line     (cur_line),
    .fill_en     (fill_en),
    .fill_line   (fill_buf),
    .merge_en    (merge_en),
    .merge_data  (wdata),
    .merge_size  (size)
  );

  always_comb begin
    state_next = state;
    unique case (state)
      mem_pkg::IDLE: begin
        if (req) begin
          state_next = mem_pkg::LOOKUP;
        end
      end
      mem_pkg::LOOKUP: begin
        if (!hit) begin
          state_next = mem_pkg::FILL_REQ;
        end else if (we) begin
          state_next = mem_pkg::MERGE;
        end else begin
          state_next = mem_pkg::DONE;
        end
      end
      mem_pkg::FILL_REQ: begin
        if (mem_ack) begin
          state_next = mem_pkg::FILL;
        end
      end
      // line is written into the array here, then looked up again
      mem_pkg::FILL:      state_next = mem_pkg::LOOKUP;
      mem_pkg::MERGE:     state_next = mem_pkg::WRITE_REQ;
      mem_pkg::WRITE_REQ: begin
        if (mem_ack) begin
          state_next = mem_pkg::DONE;
        end
      end
      mem_pkg::DONE:      state_next = mem_pkg::IDLE;
      default:            state_next = mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == mem_pkg::FILL_REQ && mem_ack) begin
      fill_buf <= mem_rdata;
    end
    if (state == mem_pkg::LOOKUP && hit && !we) begin
      rdata <= extract(cur_line, addr, size);
    end
  end

  assign fill_en  = (state == mem_pkg::FILL);
  assign merge_en = (state == mem_pkg::MERGE);
  assign done     = (state == mem_pkg::DONE);

  // fills read the line, write-through sends the merged line back
  assign mem_req   = (state == mem_pkg::FILL_REQ) || (state == mem_pkg::WRITE_REQ);
  assign mem_we    = (state == mem_pkg::WRITE_REQ);
  assign mem_addr  = addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
  assign mem_wdata = cur_line;

endmodule

/* cache_array.sv */
/*
 * Valid, tag and data storage of one direct-mapped cache.
 * Lookup is combinational; fill and byte merge write on the clock edge.
 */
`timescale 1ns/1ns

module cache_array #(
  parameter int NUM_LINES = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  cache_pkg::addr_t   lookup_addr,
  output logic               hit,
  output mem_pkg::line_t     rd_line,
  input  logic               fill_en,
  input  mem_pkg::line_t     fill_line,
  input  logic               merge_en,
  input  cache_pkg::word_t   merge_data,
  input  cache_pkg::size_e   merge_size
);

  localparam int INDEX_BITS = $clog2(NUM_LINES);
  localparam int TAG_BITS   = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - INDEX_BITS;
  localparam int LANE_BITS  = $clog2(cache_pkg::WORD_BYTES);
  localparam int WSEL_BITS  = cache_pkg::OFFSET_BITS - LANE_BITS;

  logic [NUM_LINES-1:0]            valid_q;
  logic [TAG_BITS-1:0]             tag_q [NUM_LINES];
  mem_pkg::line_t                  data_q [NUM_LINES];

  logic [INDEX_BITS-1:0]           index;
  logic [TAG_BITS-1:0]             tag;
  logic [WSEL_BITS-1:0]            word_sel;
  logic [LANE_BITS-1:0]            lane;
  logic [cache_pkg::WORD_BYTES-1:0] byte_en;
  cache_pkg::word_t                lane_data;

  // address split: tag | index | word | byte lane
  assign index    = lookup_addr[cache_pkg::OFFSET_BITS +: INDEX_BITS];
  assign tag      = lookup_addr[cache_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign word_sel = lookup_addr[LANE_BITS +: WSEL_BITS];
  assign lane     = lookup_addr[LANE_BITS-1:0];

  assign hit     = valid_q[index] && (tag_q[index] == tag);
  assign rd_line = data_q[index];

  // byte enables and data moved up to the addressed lane
  always_comb begin
    unique case (merge_size)
      cache_pkg::SIZE_8:  byte_en = 8'h01;
      cache_pkg::SIZE_16: byte_en = 8'h03;
      cache_pkg::SIZE_32: byte_en = 8'h0f;
      default:            byte_en = 8'hff;
    endcase
    byte_en   = byte_en << lane;
    lane_data = merge_data << (lane * 8);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[index] <= 1'b1;
    end
  end

  // a fill replaces the line, a merge touches only the enabled bytes
  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_q[index] <= fill_line;
      tag_q[index]  <= tag;
    end else if (merge_en) begin
      for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
        if (byte_en[b]) begin
          data_q[index][(word_sel * cache_pkg::WORD_BYTES + b) * 8 +: 8] <=
            lane_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* mem_pkg.sv */
/*
 * Memory-side types for the line bus between caches, arbiter and memory,
 * plus the cache controller state encoding.
 */
package mem_pkg;

  // one full cache line, 64 bytes
  localparam int LINE_BITS = 512;

  // address with the 6 offset bits dropped
  localparam int LINE_ADDR_BITS = 26;

  typedef logic [LINE_BITS-1:0] line_t;

  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

  // cache controller sequence
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    FILL_REQ  = 3'd2,
    FILL      = 3'd3,
    MERGE     = 3'd4,
    WRITE_REQ = 3'd5,
    DONE      = 3'd6
  } ctrl_state_e;

endpackage

/* cache_pkg.sv */
/*
 * Requester-side types shared by the caches and the testbench.
 * Referenced by scoped name, for example cache_pkg::addr_t.
 */
package cache_pkg;

  // byte address seen by a requester
  localparam int ADDR_BITS = 32;

  // data word carried on rdata and wdata
  localparam int WORD_BITS = 64;

  // bytes per data word
  localparam int WORD_BYTES = WORD_BITS / 8;

  // byte offset within a 64 byte line
  localparam int OFFSET_BITS = 6;

  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef logic [WORD_BITS-1:0] word_t;

  // access width; the byte count is 1 << size
  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2,
    SIZE_64 = 2'd3
  } size_e;

endpackage
